//--- Bender.yml
package:
  name: cpu16

sources:
  - files:
      - rtl/cpuPkg.sv
      - rtl/wordRam.sv
      - rtl/decoder.sv
      - rtl/alu.sv
      - rtl/regFile.sv
      - rtl/pcUnit.sv
      - rtl/cpuTop.sv

  - target: simulation
    files:
      - verification/cpuTrace_checker.sv
      - verification/cpuTb.sv

//--- rtl/alu.sv
module alu (
	input  logic                         clk,
	input  logic                         arstN,
	input  logic                         en,     // Instruction retires this cycle
	input  logic [3:0]                   op,
	input  logic [cpuPkg::dataWidth-1:0] a,      // rs1
	input  logic [cpuPkg::dataWidth-1:0] b,      // rs2
	output logic [cpuPkg::dataWidth-1:0] result,
	output cpuPkg::flagsT                flags
);

	logic [cpuPkg::dataWidth:0] sum; // Extra top bit is the carry
	logic                       isAdd;

	assign sum   = {1'b0, a} + {1'b0, b};
	assign isAdd = (op == cpuPkg::opAdd);

	// Everything but ADD passes a through
	assign result = isAdd ? sum[cpuPkg::dataWidth-1:0] : a;

	// Flags only move on a retiring ADD
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else if (en && isAdd) begin
			flags.carry <= sum[cpuPkg::dataWidth];
			flags.zero  <= (sum[cpuPkg::dataWidth-1:0] == '0);
		end
	end

endmodule

//--- rtl/cpuPkg.sv
package cpuPkg;

	// Datapath sizes
	localparam int dataWidth    = 16;
	localparam int pcWidth      = 8;  // Also the memory address width
	localparam int regAddrWidth = 2;  // Four registers

	// Opcodes in the top nibble of every instruction
	localparam logic [3:0] opAdd = 4'd0; // rd = rs1 + rs2
	localparam logic [3:0] opLdi = 4'd1; // rd = payload
	localparam logic [3:0] opLdr = 4'd2; // rd = dmem[rs1]
	localparam logic [3:0] opMv  = 4'd3; // rd = rs1
	localparam logic [3:0] opSt  = 4'd4; // dmem[rs1] = rs2
	localparam logic [3:0] opBri = 4'd5; // Conditional jump to payload
	localparam logic [3:0] opBrr = 4'd6; // Conditional jump to rs1

	// Next PC source
	typedef enum logic [1:0] {
		pcInc = 2'd0,
		pcImm = 2'd1,
		pcReg = 2'd2
	} pcSelT;

	// Register form, used by ADD, MV, LDR, ST
	typedef struct packed {
		logic [3:0]              opcode;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] rs1;
		logic [regAddrWidth-1:0] rs2;
		logic [5:0]              unused;
	} regFormT;

	// Immediate form, LDI
	typedef struct packed {
		logic [3:0]              opcode;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] rs1;
		logic [7:0]              payload;
	} immFormT;

	// Branch form, BRI and BRR
	typedef struct packed {
		logic [3:0]              opcode;
		logic                    flagSel; // 0 carry, 1 zero
		logic                    flagVal; // Value the flag must hold
		logic [regAddrWidth-1:0] rs1;     // BRR target register
		logic [7:0]              payload; // BRI target
	} branchFormT;

	// One instruction word, three views
	typedef union packed {
		regFormT    regForm;
		immFormT    immForm;
		branchFormT branchForm;
	} instrT;

	typedef struct packed {
		logic carry;
		logic zero;
	} flagsT;

	// Decoder output
	typedef struct packed {
		logic [3:0]              aluOp;
		pcSelT                   nextPcSel;
		logic                    regWe;
		logic                    immSel;   // Write back instrData
		logic                    memToReg; // Write back dmem read data
		logic                    memWe;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] rs1;
		logic [regAddrWidth-1:0] rs2;
		logic [dataWidth-1:0]    instrData;
	} ctrlT;

	// Register write seen on the trace
	typedef struct packed {
		logic                    valid;
		logic [regAddrWidth-1:0] regAddr;
		logic [dataWidth-1:0]    data;
	} wbTraceT;

	// Data memory write seen on the trace
	typedef struct packed {
		logic                 valid;
		logic [pcWidth-1:0]   addr;
		logic [dataWidth-1:0] data;
	} memTraceT;

endpackage

//--- rtl/cpuTop.sv
module cpuTop (
	input  logic                         clk,
	input  logic                         arstN,
	input  logic                         run,      // Level, low holds the core
	input  logic                         imemWe,   // Program load strobe
	input  logic [cpuPkg::pcWidth-1:0]   imemAddr,
	input  logic [cpuPkg::dataWidth-1:0] imemData,
	output logic [cpuPkg::pcWidth-1:0]   pc,       // Instruction now executing
	output cpuPkg::wbTraceT              wbTrace,
	output cpuPkg::memTraceT             memTrace
);

	cpuPkg::instrT instr;
	cpuPkg::ctrlT  ctrl;
	cpuPkg::flagsT flags;

	logic [cpuPkg::dataWidth-1:0] rs1Data;
	logic [cpuPkg::dataWidth-1:0] rs2Data;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic [cpuPkg::dataWidth-1:0] dmemRData;
	logic [cpuPkg::dataWidth-1:0] wbData;
	logic [cpuPkg::pcWidth-1:0]   dAddr;
	logic                         regWeRun; // Write enables gated by run
	logic                         memWeRun;

	assign regWeRun = ctrl.regWe & run;
	assign memWeRun = ctrl.memWe & run;
	assign dAddr    = rs1Data[cpuPkg::pcWidth-1:0]; // Both LDR and ST address from rs1

	// Instruction memory, written only by the load port
	wordRam iImem (
		.clk   (clk),
		.we    (imemWe),
		.wAddr (imemAddr),
		.rAddr (pc),
		.wData (imemData),
		.rData (instr)
	);

	decoder iDecoder (
		.instruction (instr),
		.flags       (flags),
		.ctrl        (ctrl)
	);

	regFile iRegFile (
		.clk    (clk),
		.arstN  (arstN),
		.we     (regWeRun),
		.wAddr  (ctrl.rd),
		.rAddr1 (ctrl.rs1),
		.rAddr2 (ctrl.rs2),
		.wData  (wbData),
		.rData1 (rs1Data),
		.rData2 (rs2Data)
	);

	alu iAlu (
		.clk    (clk),
		.arstN  (arstN),
		.en     (run),
		.op     (ctrl.aluOp),
		.a      (rs1Data),
		.b      (rs2Data),
		.result (aluResult),
		.flags  (flags)
	);

	pcUnit iPcUnit (
		.clk       (clk),
		.arstN     (arstN),
		.en        (run),
		.sel       (ctrl.nextPcSel),
		.immTarget (ctrl.instrData[cpuPkg::pcWidth-1:0]),
		.regTarget (dAddr), // Low byte of rs1
		.pc        (pc)
	);

	// Data memory, ST writes rs2 at rs1
	wordRam iDmem (
		.clk   (clk),
		.we    (memWeRun),
		.wAddr (dAddr),
		.rAddr (dAddr),
		.wData (rs2Data),
		.rData (dmemRData)
	);

	// Write-back source
	always_comb begin
		if (ctrl.memToReg) begin
			wbData = dmemRData;
		end else if (ctrl.immSel) begin
			wbData = ctrl.instrData;
		end else begin
			wbData = aluResult;
		end
	end

	// Trace shows this cycle's writes
	assign wbTrace.valid   = regWeRun;
	assign wbTrace.regAddr = ctrl.rd;
	assign wbTrace.data    = wbData;

	assign memTrace.valid = memWeRun;
	assign memTrace.addr  = dAddr;
	assign memTrace.data  = rs2Data;

endmodule

//--- rtl/decoder.sv
module decoder (
	input  cpuPkg::instrT instruction,
	input  cpuPkg::flagsT flags,
	output cpuPkg::ctrlT  ctrl
);

	logic [3:0] opcode;
	logic [7:0] payload;
	logic       flagHit; // Branch condition met

	// Fields sit at fixed positions whatever the opcode
	assign opcode  = instruction.regForm.opcode;
	assign payload = instruction.branchForm.payload; // Same bits as the LDI payload

	// Compare against carry or zero
	assign flagHit = instruction.branchForm.flagSel ?
		(instruction.branchForm.flagVal == flags.zero) :
		(instruction.branchForm.flagVal == flags.carry);

	always_comb begin
		// Defaults are all inactive
		ctrl.aluOp     = opcode;
		ctrl.nextPcSel = cpuPkg::pcInc;
		ctrl.regWe     = 1'b0;
		ctrl.immSel    = 1'b0;
		ctrl.memToReg  = 1'b0;
		ctrl.memWe     = 1'b0;
		ctrl.rd        = instruction.regForm.rd;
		ctrl.rs1       = instruction.regForm.rs1;
		ctrl.rs2       = instruction.regForm.rs2;
		ctrl.instrData = '0;

		case (opcode)
			cpuPkg::opAdd: begin
				ctrl.regWe = 1'b1; // Sum goes back to rd
			end

			cpuPkg::opLdi: begin
				ctrl.regWe     = 1'b1;
				ctrl.immSel    = 1'b1; // rd from the payload
				ctrl.instrData = {{(cpuPkg::dataWidth - 8){1'b0}}, payload};
			end

			cpuPkg::opLdr: begin
				ctrl.regWe    = 1'b1;
				ctrl.memToReg = 1'b1; // rd from dmem[rs1]
			end

			cpuPkg::opMv: begin
				ctrl.regWe = 1'b1; // ALU passes rs1 through
			end

			cpuPkg::opSt: begin
				ctrl.memWe = 1'b1; // dmem[rs1] = rs2
			end

			cpuPkg::opBri: begin
				// Payload always extracted, only used when taken
				ctrl.instrData = {{(cpuPkg::dataWidth - 8){1'b0}}, payload};
				if (flagHit) begin
					ctrl.nextPcSel = cpuPkg::pcImm;
				end
			end

			cpuPkg::opBrr: begin
				if (flagHit) begin
					ctrl.nextPcSel = cpuPkg::pcReg; // Jump to rs1
				end
			end

			default: begin
				// Unknown opcode runs as a no-op
			end
		endcase
	end

endmodule

//--- rtl/pcUnit.sv
module pcUnit (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       en,        // Low holds the PC
	input  cpuPkg::pcSelT              sel,
	input  logic [cpuPkg::pcWidth-1:0] immTarget, // BRI payload
	input  logic [cpuPkg::pcWidth-1:0] regTarget, // Low bits of rs1
	output logic [cpuPkg::pcWidth-1:0] pc
);

	logic [cpuPkg::pcWidth-1:0] pcNext;

	always_comb begin
		case (sel)
			cpuPkg::pcImm: pcNext = immTarget;
			cpuPkg::pcReg: pcNext = regTarget;
			default:       pcNext = pc + 1'b1; // Wraps at 255
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (en) begin
			pc <= pcNext;
		end
	end

endmodule

//--- rtl/regFile.sv
module regFile (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            we,
	input  logic [cpuPkg::regAddrWidth-1:0] wAddr,
	input  logic [cpuPkg::regAddrWidth-1:0] rAddr1,
	input  logic [cpuPkg::regAddrWidth-1:0] rAddr2,
	input  logic [cpuPkg::dataWidth-1:0]    wData,
	output logic [cpuPkg::dataWidth-1:0]    rData1,
	output logic [cpuPkg::dataWidth-1:0]    rData2
);

	localparam int numRegs = 2 ** cpuPkg::regAddrWidth;

	logic [cpuPkg::dataWidth-1:0] regs [numRegs];

	// Single write port
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wAddr] <= wData;
		end
	end

	// Reads see the old value during a write, no bypass
	assign rData1 = regs[rAddr1];
	assign rData2 = regs[rAddr2];

endmodule

//--- rtl/wordRam.sv
module wordRam (
	input  logic                         clk,
	input  logic                         we,
	input  logic [cpuPkg::pcWidth-1:0]   wAddr,
	input  logic [cpuPkg::pcWidth-1:0]   rAddr,
	input  logic [cpuPkg::dataWidth-1:0] wData,
	output logic [cpuPkg::dataWidth-1:0] rData
);

	localparam int depth = 2 ** cpuPkg::pcWidth;

	// Contents survive reset
	logic [cpuPkg::dataWidth-1:0] mem [depth];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wAddr] <= wData;
		end
	end

	assign rData = mem[rAddr]; // Asynchronous read

endmodule

//--- sim.f
rtl/cpuPkg.sv
rtl/wordRam.sv
rtl/decoder.sv
rtl/alu.sv
rtl/regFile.sv
rtl/pcUnit.sv
rtl/cpuTop.sv
verification/cpuTrace_checker.sv
verification/cpuTb.sv

//--- verification/cpuTb.sv
module cpuTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod      = 4;
	localparam int fillCycles     = 260; // Whole imem plus slack
	localparam int numDirected    = 5;
	localparam int directedCycles = 60;  // Reset, load and run of one short program
	localparam int randomCycles   = 150; // 64 loads and 64 retires
	localparam int marginCycles   = 100;
	localparam int cycleBudget    = fillCycles + numDirected * directedCycles
		+ randomCycles + marginCycles;
	localparam logic [31:0] lfsrSeed = 32'hcb60aac8;

	logic                         clk;
	logic                         arstN;
	logic                         run;
	logic                         imemWe;
	logic [cpuPkg::pcWidth-1:0]   imemAddr;
	logic [cpuPkg::dataWidth-1:0] imemData;
	logic [cpuPkg::pcWidth-1:0]   pc;
	cpuPkg::wbTraceT              wbTrace;
	cpuPkg::memTraceT             memTrace;

	// Reference model state
	logic [15:0] mRegs [4];
	logic [15:0] mImem [256];
	logic [15:0] mDmem [256];
	logic        mCarry;
	logic        mZero;
	logic [7:0]  mPc;

	logic [31:0] lfsrState;
	int          checkCount;
	int          errorCount;

	cpuTop i_dut (
		.clk      (clk),
		.arstN    (arstN),
		.run      (run),
		.imemWe   (imemWe),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.pc       (pc),
		.wbTrace  (wbTrace),
		.memTrace (memTrace)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState); // One step per bit
			r = {r[14:0], lfsrState[0]};
		end
		return r;
	endfunction

	// Instruction encoders for the three field layouts
	function automatic logic [15:0] encReg(input logic [3:0] op, input logic [1:0] rd,
		input logic [1:0] rs1, input logic [1:0] rs2);
		return {op, rd, rs1, rs2, 6'b0};
	endfunction

	function automatic logic [15:0] encImm(input logic [3:0] op, input logic [1:0] rd,
		input logic [7:0] payload);
		return {op, rd, 2'b00, payload};
	endfunction

	function automatic logic [15:0] encBr(input logic [3:0] op, input logic flagSel,
		input logic flagVal, input logic [1:0] rs1, input logic [7:0] target);
		return {op, flagSel, flagVal, rs1, target};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			errorCount++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic loadWord(input logic [7:0] addr, input logic [15:0] word);
		@(posedge clk);
		imemWe   <= 1'b1;
		imemAddr <= addr;
		imemData <= word;
		mImem[addr] = word;
	endtask

	task automatic endLoad();
		@(posedge clk);
		imemWe <= 1'b0;
	endtask

	task automatic applyReset();
		@(posedge clk);
		arstN <= 1'b0;
		run   <= 1'b0;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			mRegs[i] = '0;
		end
		mCarry = 1'b0;
		mZero  = 1'b0;
		mPc    = '0;
	endtask

	// One retiring cycle checked at the falling edge and modelled at the rising edge
	task automatic stepCycle();
		logic [15:0] word;
		logic [3:0]  op;
		logic [1:0]  rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [16:0] sum;
		logic        hit;
		logic        expWb;
		logic        expMem;
		logic [15:0] expWbData;
		logic [7:0]  nextPc;
		@(negedge clk);
		word = mImem[mPc];
		op   = word[15:12];
		rd   = word[11:10];
		a    = mRegs[word[9:8]];
		b    = mRegs[word[7:6]];
		sum  = {1'b0, a} + {1'b0, b};
		hit  = word[11] ? (word[10] == mZero) : (word[10] == mCarry); // Zero or carry
		expWb     = 1'b0;
		expMem    = 1'b0;
		expWbData = '0;
		nextPc    = mPc + 8'd1;
		case (op)
			cpuPkg::opAdd: begin
				expWb     = 1'b1;
				expWbData = sum[15:0];
			end
			cpuPkg::opLdi: begin
				expWb     = 1'b1;
				expWbData = {8'h00, word[7:0]}; // Zero-extended
			end
			cpuPkg::opLdr: begin
				expWb     = 1'b1;
				expWbData = mDmem[a[7:0]];
			end
			cpuPkg::opMv: begin
				expWb     = 1'b1;
				expWbData = a;
			end
			cpuPkg::opSt: expMem = 1'b1;
			cpuPkg::opBri: if (hit) nextPc = word[7:0];
			cpuPkg::opBrr: if (hit) nextPc = a[7:0]; // Low byte of rs1
			default: begin
			end
		endcase
		checkValue("pc", pc, mPc);
		checkValue("flags", {i_dut.flags.carry, i_dut.flags.zero}, {mCarry, mZero});
		checkValue("wbTrace.valid", wbTrace.valid, expWb);
		if (expWb) begin
			checkValue("wbTrace.regAddr", wbTrace.regAddr, rd);
			checkValue("wbTrace.data", wbTrace.data, expWbData);
		end
		checkValue("memTrace.valid", memTrace.valid, expMem);
		if (expMem) begin
			checkValue("memTrace.addr", memTrace.addr, a[7:0]);
			checkValue("memTrace.data", memTrace.data, b);
		end
		@(posedge clk);
		if (expWb) mRegs[rd] = expWbData;
		if (expMem) mDmem[a[7:0]] = b;
		if (op == cpuPkg::opAdd) begin
			mCarry = sum[16];
			mZero  = (sum[15:0] == 16'h0000);
		end
		mPc = nextPc;
	endtask

	task automatic runProgram(input int n);
		@(posedge clk);
		run <= 1'b1;
		repeat (n) stepCycle();
		run <= 1'b0; // Last instruction already retired at this edge
	endtask

	task automatic checkIdle();
		@(negedge clk);
		checkValue("pc", pc, mPc);
		checkValue("wbTrace.valid", wbTrace.valid, 1'b0);
		checkValue("memTrace.valid", memTrace.valid, 1'b0);
	endtask

	// Opcode 15 no-ops carrying their own address in the low byte
	task automatic fillImem();
		for (int i = 0; i < 256; i++) begin
			loadWord(i, {8'hf0, 8'(i)});
		end
		endLoad();
	endtask

	task automatic testResetHold();
		applyReset();
		checkIdle();
		runProgram(3);
		repeat (5) checkIdle(); // pc parked at 3
	endtask

	task automatic testWriteBack();
		applyReset();
		loadWord(0, encImm(cpuPkg::opLdi, 0, 8'h34));
		loadWord(1, encImm(cpuPkg::opLdi, 1, 8'hc2));
		loadWord(2, encReg(cpuPkg::opMv, 2, 0, 0));
		loadWord(3, encReg(cpuPkg::opAdd, 3, 1, 2));
		loadWord(4, encReg(cpuPkg::opAdd, 3, 3, 3));
		endLoad();
		runProgram(5);
	endtask

	task automatic testFlagBranch();
		applyReset();
		loadWord(0, encImm(cpuPkg::opLdi, 0, 8'h80));
		for (int i = 1; i <= 8; i++) begin
			loadWord(i, encReg(cpuPkg::opAdd, 0, 0, 0)); // Doubling up to 0x8000
		end
		loadWord(9, encReg(cpuPkg::opAdd, 1, 0, 0));   // Carry and zero both set
		loadWord(10, encBr(cpuPkg::opBri, 0, 1, 0, 8'd14));
		loadWord(14, encBr(cpuPkg::opBri, 1, 0, 0, 8'd40));
		loadWord(15, encBr(cpuPkg::opBri, 1, 1, 0, 8'd20));
		loadWord(20, encImm(cpuPkg::opLdi, 2, 8'h01));
		loadWord(21, encReg(cpuPkg::opAdd, 3, 2, 2)); // Both flags clear
		loadWord(22, encBr(cpuPkg::opBri, 0, 1, 0, 8'd50));
		loadWord(23, encBr(cpuPkg::opBri, 0, 0, 0, 8'd30));
		loadWord(30, encBr(cpuPkg::opBri, 1, 0, 0, 8'd34));
		loadWord(34, encBr(cpuPkg::opBri, 1, 1, 0, 8'd60));
		endLoad();
		runProgram(19);
	endtask

	task automatic testRegBranch();
		applyReset();
		loadWord(0, encImm(cpuPkg::opLdi, 1, 8'ha0));
		loadWord(1, encReg(cpuPkg::opAdd, 1, 1, 1)); // r1 = 0x140
		loadWord(2, encBr(cpuPkg::opBrr, 0, 0, 1, 8'h00));
		loadWord(8'h40, encBr(cpuPkg::opBrr, 1, 1, 1, 8'h00));
		loadWord(8'h41, encBr(cpuPkg::opBrr, 0, 1, 1, 8'h00));
		loadWord(8'h42, encBr(cpuPkg::opBrr, 1, 0, 1, 8'h00));
		endLoad();
		runProgram(6);
	endtask

	task automatic testStoreLoad();
		applyReset();
		loadWord(0, encImm(cpuPkg::opLdi, 0, 8'h17));
		loadWord(1, encImm(cpuPkg::opLdi, 1, 8'hbe));
		loadWord(2, encReg(cpuPkg::opAdd, 1, 1, 1));
		loadWord(3, encReg(cpuPkg::opSt, 0, 0, 1));  // dmem[r0] = r1
		loadWord(4, encImm(cpuPkg::opLdi, 2, 8'h99));
		loadWord(5, encReg(cpuPkg::opSt, 0, 2, 0));
		loadWord(6, encReg(cpuPkg::opLdr, 3, 0, 0));
		loadWord(7, encReg(cpuPkg::opLdr, 2, 2, 0)); // Overwrites its own address reg
		endLoad();
		runProgram(8);
	endtask

	task automatic testRandom();
		logic [1:0]  pick;
		logic [1:0]  rd;
		logic [1:0]  rs1;
		logic [7:0]  low;
		logic [3:0]  op;
		applyReset();
		for (int i = 0; i < 64; i++) begin
			pick = randBits(2);
			rd   = randBits(2);
			rs1  = randBits(2);
			low  = randBits(8); // rs2 for ADD or payload for LDI
			op   = (pick < 2) ? cpuPkg::opAdd : (pick == 2) ? cpuPkg::opMv : cpuPkg::opLdi;
			loadWord(i, {op, rd, rs1, low});
		end
		endLoad();
		runProgram(64);
	endtask

	initial begin
		#(cycleBudget * clkPeriod);
		$display("Timeout: run did not finish within %0d cycles", cycleBudget);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		clk        = 1'b0;
		arstN      = 1'b0;
		run        = 1'b0;
		imemWe     = 1'b0;
		imemAddr   = '0;
		imemData   = '0;
		lfsrState  = lfsrSeed;
		checkCount = 0;
		errorCount = 0;
		fillImem();
		testResetHold();
		testWriteBack();
		testFlagBranch();
		testRegBranch();
		testStoreLoad();
		testRandom();
		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checkCount, errorCount, i_dut.iTraceChecker.failCount);
		if (errorCount == 0 && i_dut.iTraceChecker.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verification/cpuTrace_checker.sv
module cpuTraceChecker (
	input logic                       clk,
	input logic                       arstN,
	input logic                       run,
	input logic [cpuPkg::pcWidth-1:0] pc,
	input cpuPkg::wbTraceT            wbTrace,
	input cpuPkg::memTraceT           memTrace,
	input logic [3:0]                 opcode  // Opcode now executing
);

	timeunit 1ns;
	timeprecision 1ps;

	logic isBranch;
	int   failCount = 0; // Number of failed assertions

	assign isBranch = (opcode == cpuPkg::opBri) || (opcode == cpuPkg::opBrr);

	// No writes while held or in reset
	idleQuiet: assert property (@(posedge clk)
		(!run || !arstN) |-> (!wbTrace.valid && !memTrace.valid))
		else begin
			failCount++;
			$error("Trace valid while run low or reset active");
		end

	// One write path per instruction
	oneWrite: assert property (@(posedge clk) disable iff (!arstN)
		!(wbTrace.valid && memTrace.valid))
		else begin
			failCount++;
			$error("wbTrace and memTrace valid together");
		end

	// Straight-line code steps the PC by one with wrap
	pcStep: assert property (@(posedge clk) disable iff (!arstN)
		(run && !isBranch) |=> (pc == $past(pc) + 8'd1))
		else begin
			failCount++;
			$error("pc did not advance by one after a non-branch");
		end

endmodule

bind cpuTop cpuTraceChecker iTraceChecker (
	.clk      (clk),
	.arstN    (arstN),
	.run      (run),
	.pc       (pc),
	.wbTrace  (wbTrace),
	.memTrace (memTrace),
	.opcode   (ctrl.aluOp)
);
